/* fdec_pkg.sv */
// Fractional decimator shared definitions
// Sample and coefficient formats, product width and the reset
// coefficient set of the two-phase polyphase filter

`default_nettype none

package fdec_pkg;

    ////////////////////////////////////////
    // Fixed point formats
    ////////////////////////////////////////

    // Samples are Q1.15
    localparam int DATA_WIDTH  = 16;
    localparam int DATA_FRAC   = 15;

    // Coefficients are Q2.18
    localparam int COEFF_WIDTH = 20;
    localparam int COEFF_FRAC  = 18;

    localparam int PROD_WIDTH  = DATA_WIDTH + COEFF_WIDTH;

    localparam int N_PHASES    = 2;

    ////////////////////////////////////////
    // Reset coefficients
    ////////////////////////////////////////

    // Symmetric low-pass set
    // Coefficient k sits in phase k mod 2 and slot k div 2
    // Each phase sums to about 0.45
    localparam logic signed [COEFF_WIDTH-1:0] DEFAULT_COEFF [8] = '{
        -20'sd5243,
        20'sd13107,
        20'sd39322,
        20'sd70779,
        20'sd70779,
        20'sd39322,
        20'sd13107,
        -20'sd5243
    };

endpackage

`default_nettype wire

/* sample_history.sv */
// Sample history for the fractional decimator
// Keeps the tap delay line and the phase counter, presents the tap window
// including the incoming sample and flags which accepted samples fire

`default_nettype none

module sample_history #(
    parameter int DECIM_M        = 3,
    parameter int TAPS_PER_PHASE = 4
) (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic                                    valid_in,
    input  logic signed [fdec_pkg::DATA_WIDTH-1:0]  sample_in,
    output logic signed [fdec_pkg::DATA_WIDTH-1:0]  taps [TAPS_PER_PHASE],
    output logic                                    fire,
    output logic                                    phase_sel
);

    localparam int CNT_W = $clog2(DECIM_M);

    logic [CNT_W-1:0]                       count;
    logic signed [fdec_pkg::DATA_WIDTH-1:0] hist [TAPS_PER_PHASE-1];

    // Newest sample first, then older accepted samples
    always_comb begin
        taps[0] = sample_in;
        for (int j = 1; j < TAPS_PER_PHASE; j++) begin
            taps[j] = hist[j-1];
        end
    end

    // Count 1 fires the even set, count M-1 the odd set
    assign phase_sel = (count == CNT_W'(DECIM_M - 1));
    assign fire      = valid_in && ((count == CNT_W'(1)) || phase_sel);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else if (valid_in) begin
            if (count == CNT_W'(DECIM_M - 1)) begin
                count <= '0;
            end else begin
                count <= count + CNT_W'(1);
            end
        end
    end

    // History before reset reads as silence
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int j = 0; j < TAPS_PER_PHASE - 1; j++) begin
                hist[j] <= '0;
            end
        end else if (valid_in) begin
            hist[0] <= sample_in;
            for (int j = 1; j < TAPS_PER_PHASE - 1; j++) begin
                hist[j] <= hist[j-1];
            end
        end
    end

endmodule

`default_nettype wire

/* coeff_bank.sv */
// Coefficient bank for the fractional decimator
// Holds both coefficient phases, loads the default set on reset,
// takes one addressed coefficient per write and drives the
// selected phase to the MAC

`default_nettype none

module coeff_bank #(
    parameter int TAPS_PER_PHASE = 4
) (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic                                    coeff_wr_en,
    input  logic [2:0]                              coeff_addr,
    input  logic signed [fdec_pkg::COEFF_WIDTH-1:0] coeff_data,
    input  logic                                    phase_sel,
    output logic signed [fdec_pkg::COEFF_WIDTH-1:0] coeffs [TAPS_PER_PHASE]
);

    localparam int N_COEFF = fdec_pkg::N_PHASES * TAPS_PER_PHASE;

    logic signed [fdec_pkg::COEFF_WIDTH-1:0] bank [fdec_pkg::N_PHASES][TAPS_PER_PHASE];

    int wr_phase;
    int wr_slot;

    // Address splits like the coefficient number
    assign wr_phase = int'(coeff_addr) % fdec_pkg::N_PHASES;
    assign wr_slot  = int'(coeff_addr) / fdec_pkg::N_PHASES;

    ////////////////////////////////////////
    // Storage
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int k = 0; k < N_COEFF; k++) begin
                bank[k % fdec_pkg::N_PHASES][k / fdec_pkg::N_PHASES] <=
                    fdec_pkg::DEFAULT_COEFF[k];
            end
        end else if (coeff_wr_en) begin
            bank[wr_phase][wr_slot] <= coeff_data;
        end
    end

    ////////////////////////////////////////
    // Phase select
    ////////////////////////////////////////

    always_comb begin
        for (int j = 0; j < TAPS_PER_PHASE; j++) begin
            coeffs[j] = bank[phase_sel][j];
        end
    end

endmodule

`default_nettype wire

/* polyphase_mac.sv */
// Polyphase multiply-accumulate for the fractional decimator
// Registers every tap product, then sums them in a registered pairwise
// tree. Valid, bypass and raw sample tags ride along stage by stage
// so several results can be in flight

`default_nettype none

module polyphase_mac #(
    parameter int TAPS_PER_PHASE = 4
) (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic signed [fdec_pkg::DATA_WIDTH-1:0]  taps [TAPS_PER_PHASE],
    input  logic signed [fdec_pkg::COEFF_WIDTH-1:0] coeffs [TAPS_PER_PHASE],
    input  logic                                    fire,
    input  logic                                    bypass,
    input  logic signed [fdec_pkg::DATA_WIDTH-1:0]  sample_in,
    output logic signed [fdec_pkg::PROD_WIDTH+$clog2(TAPS_PER_PHASE)-1:0] acc,
    output logic                                    acc_valid,
    output logic                                    acc_bypass,
    output logic signed [fdec_pkg::DATA_WIDTH-1:0]  bypass_sample
);

    localparam int PW     = fdec_pkg::PROD_WIDTH;
    localparam int LEVELS = $clog2(TAPS_PER_PHASE);
    // Product stage plus one stage per tree level
    localparam int STAGES = LEVELS + 1;

    logic signed [PW-1:0]                   prod_q [TAPS_PER_PHASE];
    logic                                   vld_q  [STAGES];
    logic                                   byp_q  [STAGES];
    logic signed [fdec_pkg::DATA_WIDTH-1:0] raw_q  [STAGES];

    ////////////////////////////////////////
    // Products
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        for (int j = 0; j < TAPS_PER_PHASE; j++) begin
            prod_q[j] <= taps[j] * coeffs[j];
        end
    end

    ////////////////////////////////////////
    // Adder tree
    ////////////////////////////////////////

    // Level l holds TAPS_PER_PHASE >> l sums, one bit wider than level l-1
    for (genvar l = 1; l <= LEVELS; l++) begin : g_level
        localparam int NODES = TAPS_PER_PHASE >> l;

        logic signed [PW+l-2:0] in_w  [2*NODES];
        logic signed [PW+l-1:0] sum_q [NODES];

        if (l == 1) begin : g_src
            assign in_w = prod_q;
        end else begin : g_src
            assign in_w = g_level[l-1].sum_q;
        end

        always_ff @(posedge clk) begin
            for (int n = 0; n < NODES; n++) begin
                sum_q[n] <= in_w[2*n] + in_w[2*n+1];
            end
        end
    end

    assign acc = g_level[LEVELS].sum_q[0];

    ////////////////////////////////////////
    // Tags
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int s = 0; s < STAGES; s++) begin
                vld_q[s] <= 1'b0;
                byp_q[s] <= 1'b0;
            end
        end else begin
            vld_q[0] <= fire || bypass;
            byp_q[0] <= bypass;
            for (int s = 1; s < STAGES; s++) begin
                vld_q[s] <= vld_q[s-1];
                byp_q[s] <= byp_q[s-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        raw_q[0] <= sample_in;
        for (int s = 1; s < STAGES; s++) begin
            raw_q[s] <= raw_q[s-1];
        end
    end

    assign acc_valid     = vld_q[STAGES-1];
    assign acc_bypass    = byp_q[STAGES-1];
    assign bypass_sample = raw_q[STAGES-1];

endmodule

`default_nettype wire

/* round_sat.sv */
// Output stage of the fractional decimator
// Rounds the accumulator to Q1.15, clamps to the sample range with
// overflow and underflow flags, and registers the result or the
// bypassed sample

`default_nettype none

module round_sat #(
    parameter int TAPS_PER_PHASE = 4
) (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic signed [fdec_pkg::PROD_WIDTH+$clog2(TAPS_PER_PHASE)-1:0] acc,
    input  logic                                    acc_valid,
    input  logic                                    acc_bypass,
    input  logic signed [fdec_pkg::DATA_WIDTH-1:0]  bypass_sample,
    output logic signed [fdec_pkg::DATA_WIDTH-1:0]  sample_out,
    output logic                                    overflow,
    output logic                                    underflow,
    output logic                                    valid_out
);

    localparam int ACC_WIDTH = fdec_pkg::PROD_WIDTH + $clog2(TAPS_PER_PHASE);
    localparam int ACC_FRAC  = fdec_pkg::DATA_FRAC + fdec_pkg::COEFF_FRAC;
    localparam int SHIFT     = ACC_FRAC - fdec_pkg::DATA_FRAC;

    localparam logic signed [ACC_WIDTH-1:0] HALF_LSB = ACC_WIDTH'(1) << (SHIFT - 1);
    localparam logic signed [ACC_WIDTH-1:0] SAT_MAX  =
        ACC_WIDTH'(2 ** (fdec_pkg::DATA_WIDTH - 1) - 1);
    // Bitwise inverse of the top limit is the bottom limit
    localparam logic signed [ACC_WIDTH-1:0] SAT_MIN  = ~SAT_MAX;

    logic signed [ACC_WIDTH-1:0]            rounded;
    logic                                   clip_hi;
    logic                                   clip_lo;
    logic signed [fdec_pkg::DATA_WIDTH-1:0] sat_val;

    always_comb begin
        rounded = (acc + HALF_LSB) >>> SHIFT;
        clip_hi = rounded > SAT_MAX;
        clip_lo = rounded < SAT_MIN;
        if (clip_hi) begin
            sat_val = SAT_MAX[fdec_pkg::DATA_WIDTH-1:0];
        end else if (clip_lo) begin
            sat_val = SAT_MIN[fdec_pkg::DATA_WIDTH-1:0];
        end else begin
            sat_val = rounded[fdec_pkg::DATA_WIDTH-1:0];
        end
    end

    // Flags pulse with valid_out only
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_out <= 1'b0;
            overflow  <= 1'b0;
            underflow <= 1'b0;
        end else begin
            valid_out <= acc_valid;
            overflow  <= acc_valid && !acc_bypass && clip_hi;
            underflow <= acc_valid && !acc_bypass && clip_lo;
        end
    end

    always_ff @(posedge clk) begin
        if (acc_valid) begin
            sample_out <= acc_bypass ? bypass_sample : sat_val;
        end
    end

endmodule

`default_nettype wire

/* frac_decimator.sv */
// Two-phase fractional decimator, top level
// Sample history feeds the polyphase MAC with the coefficient bank
// supplying the active phase. Two outputs per DECIM_M input samples

`default_nettype none

module frac_decimator #(
    parameter int DECIM_M        = 3,
    parameter int TAPS_PER_PHASE = 4
) (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic                                    valid_in,
    input  logic signed [fdec_pkg::DATA_WIDTH-1:0]  sample_in,
    input  logic                                    bypass,
    input  logic                                    coeff_wr_en,
    input  logic [2:0]                              coeff_addr,
    input  logic signed [fdec_pkg::COEFF_WIDTH-1:0] coeff_data,
    output logic signed [fdec_pkg::DATA_WIDTH-1:0]  sample_out,
    output logic                                    overflow,
    output logic                                    underflow,
    output logic                                    valid_out
);

    localparam int ACC_WIDTH = fdec_pkg::PROD_WIDTH + $clog2(TAPS_PER_PHASE);

    logic signed [fdec_pkg::DATA_WIDTH-1:0]  taps   [TAPS_PER_PHASE];
    logic signed [fdec_pkg::COEFF_WIDTH-1:0] coeffs [TAPS_PER_PHASE];
    logic                                    fire;
    logic                                    phase_sel;
    logic signed [ACC_WIDTH-1:0]             acc;
    logic                                    acc_valid;
    logic                                    acc_bypass;
    logic signed [fdec_pkg::DATA_WIDTH-1:0]  bypass_sample;

    sample_history #(
        .DECIM_M        (DECIM_M),
        .TAPS_PER_PHASE (TAPS_PER_PHASE)
    ) u_history (
        .clk       (clk),
        .rst_n     (rst_n),
        .valid_in  (valid_in),
        .sample_in (sample_in),
        .taps      (taps),
        .fire      (fire),
        .phase_sel (phase_sel)
    );

    coeff_bank #(
        .TAPS_PER_PHASE (TAPS_PER_PHASE)
    ) u_bank (
        .clk         (clk),
        .rst_n       (rst_n),
        .coeff_wr_en (coeff_wr_en),
        .coeff_addr  (coeff_addr),
        .coeff_data  (coeff_data),
        .phase_sel   (phase_sel),
        .coeffs      (coeffs)
    );

    // Bypass only counts for accepted samples
    polyphase_mac #(
        .TAPS_PER_PHASE (TAPS_PER_PHASE)
    ) u_mac (
        .clk           (clk),
        .rst_n         (rst_n),
        .taps          (taps),
        .coeffs        (coeffs),
        .fire          (fire),
        .bypass        (bypass && valid_in),
        .sample_in     (sample_in),
        .acc           (acc),
        .acc_valid     (acc_valid),
        .acc_bypass    (acc_bypass),
        .bypass_sample (bypass_sample)
    );

    round_sat #(
        .TAPS_PER_PHASE (TAPS_PER_PHASE)
    ) u_round (
        .clk           (clk),
        .rst_n         (rst_n),
        .acc           (acc),
        .acc_valid     (acc_valid),
        .acc_bypass    (acc_bypass),
        .bypass_sample (bypass_sample),
        .sample_out    (sample_out),
        .overflow      (overflow),
        .underflow     (underflow),
        .valid_out     (valid_out)
    );

endmodule

`default_nettype wire

/* frac_decimator_chk.sv */
// Output protocol assertions for the fractional decimator
// Bound to the top level, watches reset state and the flags

`default_nettype none

module frac_decimator_chk (
    input logic clk,
    input logic rst_n,
    input logic valid_out,
    input logic overflow,
    input logic underflow
);

    a_reset_quiet: assert property (@(posedge clk) !rst_n |-> !valid_out)
        else $error("valid_out high while reset is asserted");

    // Clamping goes one way only
    a_flags_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(overflow && underflow))
        else $error("overflow and underflow high together");

    a_flags_with_valid: assert property (@(posedge clk) disable iff (!rst_n)
        (overflow || underflow) |-> valid_out)
        else $error("saturation flag high without valid_out");

endmodule

bind frac_decimator frac_decimator_chk u_chk (
    .clk       (clk),
    .rst_n     (rst_n),
    .valid_out (valid_out),
    .overflow  (overflow),
    .underflow (underflow)
);

`default_nettype wire

/* frac_decimator_tb.sv */
// Testbench for the fractional decimator
// Drives random sample streams, bypass and coefficient writes, and
// checks every output against a polyphase model kept in the testbench

`default_nettype none

module frac_decimator_tb;

    localparam int DECIM_M = 3;
    localparam int TAPS    = 4;

    logic                                    clk;
    logic                                    rst_n;
    logic                                    valid_in;
    logic signed [fdec_pkg::DATA_WIDTH-1:0]  sample_in;
    logic                                    bypass;
    logic                                    coeff_wr_en;
    logic [2:0]                              coeff_addr;
    logic signed [fdec_pkg::COEFF_WIDTH-1:0] coeff_data;
    logic signed [fdec_pkg::DATA_WIDTH-1:0]  sample_out;
    logic                                    overflow;
    logic                                    underflow;
    logic                                    valid_out;

    // Model state and expected output queue
    longint                                  coef_m [8];
    longint                                  hist_m [TAPS-1];
    int                                      count_m;
    longint                                  exp_val [$];
    logic                                    exp_ovf [$];
    logic                                    exp_unf [$];
    longint                                  exp_due [$];
    longint                                  cycle = 0;
    int                                      errors = 0;
    int                                      outputs = 0;
    int                                      ovf_hits = 0;
    int                                      unf_hits = 0;
    int                                      start_outputs;
    integer                                  seed;
    string                                   test_name = "reset";
    logic signed [fdec_pkg::COEFF_WIDTH-1:0] new_coeff;
    logic signed [fdec_pkg::DATA_WIDTH-1:0]  last_out;
    logic                                    out_seen = 1'b0;

    frac_decimator #(
        .DECIM_M        (DECIM_M),
        .TAPS_PER_PHASE (TAPS)
    ) dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .valid_in    (valid_in),
        .sample_in   (sample_in),
        .bypass      (bypass),
        .coeff_wr_en (coeff_wr_en),
        .coeff_addr  (coeff_addr),
        .coeff_data  (coeff_data),
        .sample_out  (sample_out),
        .overflow    (overflow),
        .underflow   (underflow),
        .valid_out   (valid_out)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle++;
    end

    task automatic check_equal(input string what, input logic signed [63:0] expected,
                               input logic signed [63:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("ERROR %s %s: expected %0d, actual %0d", test_name, what, expected, actual);
        end
    endtask

    task automatic push_expected(input longint value, input logic ovf, input logic unf);
        exp_val.push_back(value);
        exp_ovf.push_back(ovf);
        exp_unf.push_back(unf);
        exp_due.push_back(cycle + 4);
    endtask

    ////////////////////////////////////////
    // Stimulus and model
    ////////////////////////////////////////

    // Bypass may stay high on idle cycles, where it must have no effect
    task automatic idle_cycle(input logic byp);
        @(negedge clk);
        valid_in    = 1'b0;
        bypass      = byp;
        coeff_wr_en = 1'b0;
    endtask

    task automatic drive_sample(input logic signed [15:0] x, input logic byp);
        longint acc;
        longint rnd;
        int     p;
        logic   fires;
        @(negedge clk);
        valid_in    = 1'b1;
        sample_in   = x;
        bypass      = byp;
        coeff_wr_en = 1'b0;
        fires = (count_m == 1) || (count_m == DECIM_M - 1);
        p     = (count_m == DECIM_M - 1) ? 1 : 0;
        if (byp) begin
            push_expected(x, 1'b0, 1'b0);
        end else if (fires) begin
            acc = x * coef_m[p];
            for (int j = 1; j < TAPS; j++) begin
                acc += hist_m[j-1] * coef_m[2*j+p];
            end
            // Half output LSB, then drop the 18 extra fraction bits
            rnd = (acc + (64'sd1 <<< 17)) >>> 18;
            if (rnd > 32767) begin
                push_expected(32767, 1'b1, 1'b0);
            end else if (rnd < -32768) begin
                push_expected(-32768, 1'b0, 1'b1);
            end else begin
                push_expected(rnd, 1'b0, 1'b0);
            end
        end
        for (int j = TAPS - 2; j > 0; j--) begin
            hist_m[j] = hist_m[j-1];
        end
        hist_m[0] = x;
        count_m = (count_m == DECIM_M - 1) ? 0 : count_m + 1;
    endtask

    task automatic drive_random(input int n, input int pct, input logic byp);
        for (int i = 0; i < n; i++) begin
            if ({$random(seed)} % 100 < pct) begin
                drive_sample(16'($random(seed)), byp);
            end else begin
                idle_cycle(byp);
            end
        end
    endtask

    task automatic write_coeff(input int k, input logic signed [19:0] value);
        @(negedge clk);
        valid_in    = 1'b0;
        bypass      = 1'b0;
        coeff_wr_en = 1'b1;
        coeff_addr  = 3'(k);
        coeff_data  = value;
        coef_m[k]   = value;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_val.size() != 0 && waited < 50) begin
            idle_cycle(1'b0);
            waited++;
        end
        if (exp_val.size() != 0) begin
            errors++;
            $display("Timeout in %s: %0d expected outputs never appeared",
                     test_name, exp_val.size());
        end
    endtask

    ////////////////////////////////////////
    // Output monitor
    ////////////////////////////////////////

    always @(negedge clk) begin
        if (rst_n) begin
            while (exp_due.size() != 0 && exp_due[0] < cycle) begin
                errors++;
                $display("Missing output in %s: no result at cycle %0d", test_name, exp_due[0]);
                void'(exp_val.pop_front());
                void'(exp_ovf.pop_front());
                void'(exp_unf.pop_front());
                void'(exp_due.pop_front());
            end
            if (valid_out) begin
                outputs++;
                ovf_hits += overflow ? 1 : 0;
                unf_hits += underflow ? 1 : 0;
                if (exp_val.size() == 0) begin
                    errors++;
                    $display("Unexpected output in %s at cycle %0d", test_name, cycle);
                end else begin
                    check_equal("latency", exp_due[0], cycle);
                    check_equal("sample_out", exp_val[0], sample_out);
                    check_equal("overflow", exp_ovf[0], overflow);
                    check_equal("underflow", exp_unf[0], underflow);
                    void'(exp_val.pop_front());
                    void'(exp_ovf.pop_front());
                    void'(exp_unf.pop_front());
                    void'(exp_due.pop_front());
                end
                last_out = sample_out;
                out_seen = 1'b1;
            end else if (out_seen) begin
                // Result holds until the next valid pulse
                check_equal("sample_out hold", last_out, sample_out);
            end
        end
    end

    initial begin
        seed        = 81059;
        rst_n       = 1'b0;
        valid_in    = 1'b0;
        sample_in   = '0;
        bypass      = 1'b0;
        coeff_wr_en = 1'b0;
        coeff_addr  = '0;
        coeff_data  = '0;
        count_m     = 0;
        for (int k = 0; k < 8; k++) begin
            coef_m[k] = fdec_pkg::DEFAULT_COEFF[k];
        end
        for (int j = 0; j < TAPS - 1; j++) begin
            hist_m[j] = 0;
        end
        repeat (3) @(negedge clk);
        check_equal("valid_out", 0, valid_out);
        check_equal("overflow", 0, overflow);
        check_equal("underflow", 0, underflow);
        rst_n = 1'b1;

        test_name = "default_coeff";
        drive_random(60, 100, 1'b0);
        wait_drain();

        // 300 samples leave the phase count where it started
        test_name = "ratio";
        start_outputs = outputs;
        drive_random(300, 100, 1'b0);
        wait_drain();
        check_equal("output count", 2 * 300 / DECIM_M, outputs - start_outputs);

        test_name = "gapped";
        drive_random(200, 60, 1'b0);
        wait_drain();

        test_name = "bypass";
        drive_random(40, 70, 1'b1);
        wait_drain();

        test_name = "coeff_write";
        for (int k = 0; k < 8; k++) begin
            new_coeff = 20'($random(seed));
            write_coeff(k, new_coeff >>> 3);
        end
        drive_random(90, 80, 1'b0);
        wait_drain();

        // Near +2 coefficients, then near -2, with full-scale samples
        test_name = "saturation";
        for (int k = 0; k < 8; k++) begin
            write_coeff(k, 20'sh7FFFF);
        end
        repeat (12) drive_sample(16'sh7FFF, 1'b0);
        repeat (12) drive_sample(-16'sh8000, 1'b0);
        wait_drain();
        for (int k = 0; k < 8; k++) begin
            write_coeff(k, 20'sh80000);
        end
        repeat (12) drive_sample(16'sh7FFF, 1'b0);
        wait_drain();
        check_equal("overflow seen", 1, ovf_hits > 0);
        check_equal("underflow seen", 1, unf_hits > 0);

        $display("Errors: %0d, outputs seen: %0d", errors, outputs);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* frac_decimator.f */
fdec_pkg.sv
sample_history.sv
coeff_bank.sv
polyphase_mac.sv
round_sat.sv
frac_decimator.sv
frac_decimator_chk.sv
frac_decimator_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing
TOP       := frac_decimator_tb
FILELIST  := frac_decimator.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "^Finished with no errors$$" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
